// File: verilog/spi_bridge_params.svh
`ifndef SPI_BRIDGE_PARAMS_SVH
`define SPI_BRIDGE_PARAMS_SVH

// Command word layout.
`define SPI_CMD_WIDTH   12
`define SPI_ADDR_WIDTH  3
`define SPI_DATA_WIDTH  8

// SPI timing in system clocks.
`define SPI_HALF_PERIOD 4
`define SPI_READ_GAP    16

// Init list, all writes to distinct registers.
`define SPI_INIT_COUNT  4
`define SPI_INIT_CMD0   12'h8A5  // Reg 0 <= 0xA5.
`define SPI_INIT_CMD1   12'hB3C  // Reg 3 <= 0x3C.
`define SPI_INIT_CMD2   12'hD5A  // Reg 5 <= 0x5A.
`define SPI_INIT_CMD3   12'hE96  // Reg 6 <= 0x96.

`endif

// File: verilog/spi_bridge_pkg.sv
`include "spi_bridge_params.svh"

package spi_bridge_pkg;

  // Bit 11 is the write flag, then address, then data.
  typedef struct packed
  {
    logic                       write;
    logic [`SPI_ADDR_WIDTH-1:0] addr;
    logic [`SPI_DATA_WIDTH-1:0] data;
  } spi_cmd_fields_t;

  // Fields select the frame type, raw is what goes out on mosi.
  typedef union packed
  {
    spi_cmd_fields_t           fields;
    logic [`SPI_CMD_WIDTH-1:0] raw;
  } spi_cmd_u;

endpackage

// File: verilog/spi_cmd_arbiter.sv
module spi_cmd_arbiter
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     host_cmd_strobe,
  input  spi_bridge_pkg::spi_cmd_u host_cmd,
  input  logic                     init_cmd_strobe,
  input  spi_bridge_pkg::spi_cmd_u init_cmd,
  input  logic                     busy,
  output logic                     host_pending,
  output logic                     init_slot_free,
  output logic                     start,
  output spi_bridge_pkg::spi_cmd_u cmd,
  output logic                     init_idle
);
  import spi_bridge_pkg::*;

  spi_cmd_u host_q;
  spi_cmd_u init_q;
  logic     host_valid;
  logic     init_valid;
  logic     last_host;    // Host was granted most recently.
  logic     init_active;  // An init command is on the wire.
  logic     busy_q;
  logic     grant_host;
  logic     grant_init;

  // Round robin only matters when both slots hold a command.
  assign grant_host = !busy && host_valid && (!init_valid || !last_host);
  assign grant_init = !busy && init_valid && !grant_host;

  assign start          = grant_host || grant_init;
  assign cmd            = grant_host ? host_q : init_q;
  assign host_pending   = host_valid;
  assign init_slot_free = !init_valid;
  assign init_idle      = !init_valid && !init_active && !busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      host_valid  <= 1'b0;
      init_valid  <= 1'b0;
      last_host   <= 1'b0;
      init_active <= 1'b0;
      busy_q      <= 1'b0;
    end
    else
    begin
      host_valid <= host_cmd_strobe || (host_valid && !grant_host);
      init_valid <= init_cmd_strobe || (init_valid && !grant_init);
      busy_q     <= busy;
      if (grant_host)
        last_host <= 1'b1;
      else if (grant_init)
        last_host <= 1'b0;
      if (grant_init)
        init_active <= 1'b1;
      else if (busy_q && !busy)
        init_active <= 1'b0;  // Frame just ended.
    end
  end

  always_ff @(posedge clk)
  begin
    if (host_cmd_strobe)
      host_q <= host_cmd;
    if (init_cmd_strobe)
      init_q <= init_cmd;
  end

endmodule

// File: verilog/spi_init_sequencer.sv
`include "spi_bridge_params.svh"

module spi_init_sequencer
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     init_slot_free,
  input  logic                     init_idle,
  output logic                     init_cmd_strobe,
  output spi_bridge_pkg::spi_cmd_u init_cmd,
  output logic                     init_done
);
  import spi_bridge_pkg::*;

  localparam int IDX_W = $clog2(`SPI_INIT_COUNT + 1);

  logic [IDX_W-1:0] idx;
  logic             list_end;
  logic             issue;
  spi_cmd_u         next_cmd;

  assign list_end = (idx == IDX_W'(`SPI_INIT_COUNT));
  // Slot flag lags our own strobe by a cycle, so skip that cycle.
  assign issue    = init_slot_free && !init_cmd_strobe && !list_end;

  always_comb
  begin
    case (idx)
      IDX_W'(0): next_cmd.raw = `SPI_INIT_CMD0;
      IDX_W'(1): next_cmd.raw = `SPI_INIT_CMD1;
      IDX_W'(2): next_cmd.raw = `SPI_INIT_CMD2;
      default:   next_cmd.raw = `SPI_INIT_CMD3;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      idx             <= '0;
      init_cmd_strobe <= 1'b0;
      init_done       <= 1'b0;
    end
    else
    begin
      init_cmd_strobe <= issue;
      if (issue)
        idx <= idx + 1'b1;
      if (list_end && !init_cmd_strobe && init_idle)
        init_done <= 1'b1;  // Sticky until reset.
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      init_cmd <= next_cmd;
  end

endmodule

// File: verilog/spi_master.sv
`include "spi_bridge_params.svh"

module spi_master
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  spi_bridge_pkg::spi_cmd_u   cmd,
  input  logic                       miso,
  output logic                       busy,
  output logic                       sclk,
  output logic                       cs_n,
  output logic                       mosi,
  output logic                       read_valid,
  output logic [`SPI_DATA_WIDTH-1:0] read_data
);
  import spi_bridge_pkg::*;

  localparam int DIV_W     = $clog2(`SPI_HALF_PERIOD + 1);
  localparam int GAP_W     = $clog2(`SPI_READ_GAP + 1);
  localparam int BIT_W     = $clog2(`SPI_CMD_WIDTH);
  localparam int ADDR_BITS = 1 + `SPI_ADDR_WIDTH;  // Flag plus address of a read.

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_SHIFT  = 3'd1;  // Write frame or read address phase.
  localparam logic [2:0] ST_GAP    = 3'd2;
  localparam logic [2:0] ST_RDATA  = 3'd3;
  localparam logic [2:0] ST_FINISH = 3'd4;

  logic [2:0]                 state;
  logic [DIV_W-1:0]           div_cnt;
  logic [BIT_W-1:0]           bit_cnt;  // Bits left after the current one.
  logic [GAP_W-1:0]           gap_cnt;
  spi_cmd_u                   cmd_q;
  logic [`SPI_CMD_WIDTH-1:0]  tx_shift;
  logic [`SPI_DATA_WIDTH-1:0] rx_shift;
  logic                       half_done;
  logic                       last_bit;

  assign half_done = (div_cnt == DIV_W'(`SPI_HALF_PERIOD - 1));
  assign last_bit  = (bit_cnt == '0);
  assign read_data = rx_shift;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      gap_cnt    <= '0;
      busy       <= 1'b0;
      sclk       <= 1'b0;
      cs_n       <= 1'b1;
      mosi       <= 1'b0;
      read_valid <= 1'b0;
    end
    else
    begin
      read_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state   <= ST_SHIFT;
            busy    <= 1'b1;
            cs_n    <= 1'b0;
            mosi    <= cmd.raw[`SPI_CMD_WIDTH-1];  // MSB is ready before the first rise.
            div_cnt <= '0;
            bit_cnt <= cmd.fields.write ? BIT_W'(`SPI_CMD_WIDTH - 1) : BIT_W'(ADDR_BITS - 1);
          end
        end
        ST_SHIFT:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk <= ~sclk;
            if (sclk)
            begin
              if (last_bit)
              begin
                cs_n    <= 1'b1;
                mosi    <= 1'b0;
                gap_cnt <= '0;
                state   <= cmd_q.fields.write ? ST_FINISH : ST_GAP;
              end
              else
              begin
                bit_cnt <= bit_cnt - 1'b1;
                mosi    <= tx_shift[`SPI_CMD_WIDTH-2];  // Next bit after the fall.
              end
            end
          end
        end
        ST_GAP:
        begin
          if (gap_cnt == GAP_W'(`SPI_READ_GAP - 1))
          begin
            state   <= ST_RDATA;
            cs_n    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= BIT_W'(`SPI_DATA_WIDTH - 1);
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        ST_RDATA:
        begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done)
          begin
            sclk <= ~sclk;
            if (!sclk && last_bit)
              read_valid <= 1'b1;  // Final sample lands in rx_shift this edge.
            if (sclk)
            begin
              if (last_bit)
              begin
                cs_n  <= 1'b1;
                state <= ST_FINISH;
              end
              else
                bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        ST_FINISH:
        begin
          busy  <= 1'b0;
          state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && start)
    begin
      cmd_q    <= cmd;
      tx_shift <= cmd.raw;
    end
    else if (state == ST_SHIFT && half_done && sclk)
      tx_shift <= tx_shift << 1;
    // Sample on the rising sclk edge.
    if (state == ST_RDATA && half_done && !sclk)
      rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], miso};
  end

endmodule

// File: verilog/spi_bridge_top.sv
`include "spi_bridge_params.svh"

module spi_bridge_top
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       host_cmd_strobe,
  input  spi_bridge_pkg::spi_cmd_u   host_cmd,
  input  logic                       miso,
  output logic                       host_pending,
  output logic                       read_valid,
  output logic [`SPI_DATA_WIDTH-1:0] read_data,
  output logic                       init_done,
  output logic                       sclk,
  output logic                       cs_n,
  output logic                       mosi
);
  import spi_bridge_pkg::*;

  logic     init_cmd_strobe;
  spi_cmd_u init_cmd;
  logic     init_slot_free;
  logic     init_idle;
  logic     start;
  spi_cmd_u cmd;
  logic     busy;

  spi_init_sequencer u_init_sequencer
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .init_slot_free  (init_slot_free),
    .init_idle       (init_idle),
    .init_cmd_strobe (init_cmd_strobe),
    .init_cmd        (init_cmd),
    .init_done       (init_done)
  );

  spi_cmd_arbiter u_cmd_arbiter
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .host_cmd_strobe (host_cmd_strobe),
    .host_cmd        (host_cmd),
    .init_cmd_strobe (init_cmd_strobe),
    .init_cmd        (init_cmd),
    .busy            (busy),
    .host_pending    (host_pending),
    .init_slot_free  (init_slot_free),
    .start           (start),
    .cmd             (cmd),
    .init_idle       (init_idle)
  );

  // Reads only come from the host, so read results go straight out.
  spi_master u_master
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cmd        (cmd),
    .miso       (miso),
    .busy       (busy),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .read_valid (read_valid),
    .read_data  (read_data)
  );

endmodule

// File: bench/spi_device_model.sv
`include "spi_bridge_params.svh"

module spi_device_model
#(
  parameter logic [`SPI_DATA_WIDTH-1:0] FILL = 8'hC0
)
(
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic frame_error
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW   = `SPI_DATA_WIDTH;
  localparam int AW   = `SPI_ADDR_WIDTH;
  localparam int CW   = `SPI_CMD_WIDTH;
  localparam int REGS = 1 << AW;

  logic [DW-1:0] regs [REGS];
  logic [CW-1:0] rx_bits;
  logic [DW-1:0] tx_bits;
  logic [AW-1:0] read_addr;
  logic          data_phase;  // Next frame carries read data.
  logic          sclk_q;
  logic          cs_q;
  int            bit_count;

  task automatic report_bad_frame(input string kind);
    $display("SPI device model: %s frame had %0d clock edges, expected 12 or 4 then 8",
             kind, bit_count);
    frame_error = 1'b1;
  endtask

  // Decode a frame once cs_n goes back high.
  task automatic end_frame();
    if (data_phase)
    begin
      if (bit_count != DW)
        report_bad_frame("read data");
      data_phase = 1'b0;
    end
    else if (bit_count == CW && rx_bits[CW-1])
      regs[rx_bits[CW-2 -: AW]] = rx_bits[DW-1:0];
    else if (bit_count == 1 + AW && !rx_bits[AW])
    begin
      read_addr  = rx_bits[AW-1:0];
      data_phase = 1'b1;
    end
    else
      report_bad_frame("command");
  endtask

  initial
  begin
    for (int i = 0; i < REGS; i++)
      regs[i] = FILL ^ DW'(i * 17);  // Every address bit shows in the fill.
    rx_bits     = '0;
    tx_bits     = '0;
    read_addr   = '0;
    data_phase  = 1'b0;
    sclk_q      = 1'b0;
    cs_q        = 1'b1;
    bit_count   = 0;
    miso        = 1'b0;
    frame_error = 1'b0;
    forever
    begin
      @(sclk or cs_n or rst_n);
      if (rst_n)
      begin
        if (cs_q && !cs_n)
        begin
          bit_count = 0;
          rx_bits   = '0;
          if (data_phase)
          begin
            tx_bits = regs[read_addr];
            miso    = tx_bits[DW-1];  // MSB ready before the first rise.
          end
        end
        if (!cs_n && !sclk_q && sclk)
        begin
          rx_bits   = {rx_bits[CW-2:0], mosi};
          bit_count = bit_count + 1;
        end
        if (!cs_n && sclk_q && !sclk && data_phase && bit_count < DW)
        begin
          tx_bits = tx_bits << 1;
          miso    = tx_bits[DW-1];
        end
        if (!cs_q && cs_n)
          end_frame();
      end
      sclk_q = sclk;
      cs_q   = cs_n;
    end
  end

endmodule

// File: bench/tb_spi_bridge.sv
`include "spi_bridge_params.svh"

module tb_spi_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         WAIT_LIMIT = 2000;  // Clock cycles per wait.
  localparam logic [7:0] FILL       = 8'hC0;

  logic        clk;
  logic        rst_n;
  logic        host_cmd_strobe;
  logic [11:0] host_cmd;
  logic        miso;
  logic        host_pending;
  logic        read_valid;
  logic [7:0]  read_data;
  logic        init_done;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        frame_error;
  logic [7:0]  mirror [8];  // Expected device register contents.
  integer      seed;

  spi_bridge_top dut
  (
    .clk             (clk),
    .rst_n           (rst_n),
    .host_cmd_strobe (host_cmd_strobe),
    .host_cmd        (host_cmd),
    .miso            (miso),
    .host_pending    (host_pending),
    .read_valid      (read_valid),
    .read_data       (read_data),
    .init_done       (init_done),
    .sclk            (sclk),
    .cs_n            (cs_n),
    .mosi            (mosi)
  );

  spi_device_model #(.FILL(FILL)) u_device
  (
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .frame_error (frame_error)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
    else
      abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  task automatic wait_host_free();
    int n;
    n = 0;
    while (host_pending && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (host_pending)
      abort_run("Timed out waiting for host_pending to fall");
  endtask

  task automatic wait_read_valid();
    int n;
    n = 0;
    while (!read_valid && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!read_valid)
      abort_run("Timed out waiting for read_valid after a host read");
  endtask

  task automatic wait_init_done();
    int n;
    n = 0;
    while (!init_done && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!init_done)
      abort_run("Timed out waiting for init_done");
  endtask

  // One-cycle strobe, only into an empty host slot.
  task automatic send_host_cmd(input logic [11:0] word);
    wait_host_free();
    host_cmd        = word;
    host_cmd_strobe = 1'b1;
    @(negedge clk);
    host_cmd_strobe = 1'b0;
    check_value("host_pending", 32'(host_pending), 32'h1);
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
    send_host_cmd({1'b1, addr, data});
    mirror[addr] = data;
  endtask

  task automatic read_and_compare(input logic [2:0] addr, input logic [7:0] expected);
    send_host_cmd({1'b0, addr, 8'h00});
    wait_read_valid();
    check_value("read_data", 32'(read_data), 32'(expected));
    @(negedge clk);
    check_value("read_valid", 32'(read_valid), 32'h0);  // Single-cycle strobe.
  endtask

  task automatic verify_reset_values();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("cs_n", 32'(cs_n), 32'h1);
    check_value("sclk", 32'(sclk), 32'h0);
    check_value("mosi", 32'(mosi), 32'h0);
    check_value("read_valid", 32'(read_valid), 32'h0);
    check_value("host_pending", 32'(host_pending), 32'h0);
    check_value("init_done", 32'(init_done), 32'h0);
  endtask

  // Host addresses kept clear of the init list.
  task automatic write_during_init();
    host_write(3'd2, 8'h4E);
    host_write(3'd7, 8'h1B);
    check_value("init_done", 32'(init_done), 32'h0);
  endtask

  task automatic init_sequence_readback();
    logic [11:0] init_list [`SPI_INIT_COUNT];
    init_list = '{`SPI_INIT_CMD0, `SPI_INIT_CMD1, `SPI_INIT_CMD2, `SPI_INIT_CMD3};
    for (int i = 0; i < `SPI_INIT_COUNT; i++)
      mirror[init_list[i][10:8]] = init_list[i][7:0];
    wait_init_done();
    for (int i = 0; i < `SPI_INIT_COUNT; i++)
      read_and_compare(init_list[i][10:8], init_list[i][7:0]);
  endtask

  task automatic sweep_all_registers();
    for (int i = 0; i < 8; i++)
      read_and_compare(3'(i), mirror[i]);
  endtask

  task automatic write_then_read_back();
    host_write(3'd4, 8'h3D);
    read_and_compare(3'd4, 8'h3D);
    host_write(3'd3, 8'hC7);  // Overwrites an init value.
    read_and_compare(3'd3, 8'hC7);
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    seed = 9;
    repeat (24)
    begin
      r = $random(seed);
      if (r[0])
        host_write(r[3:1], r[11:4]);
      else
        read_and_compare(r[3:1], mirror[r[3:1]]);
    end
  endtask

  initial
  begin
    @(posedge frame_error);
    abort_run("SPI device model saw a malformed frame");
  end

  initial
  begin
    rst_n           = 1'b0;
    host_cmd_strobe = 1'b0;
    host_cmd        = '0;
    seed            = 9;
    for (int i = 0; i < 8; i++)
      mirror[i] = FILL ^ 8'(i * 17);
    verify_reset_values();
    write_during_init();
    init_sequence_readback();
    sweep_all_registers();
    write_then_read_back();
    random_traffic();
    sweep_all_registers();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: spi_bridge.f
+incdir+verilog
verilog/spi_bridge_pkg.sv
verilog/spi_cmd_arbiter.sv
verilog/spi_init_sequencer.sv
verilog/spi_master.sv
verilog/spi_bridge_top.sv
bench/spi_device_model.sv
bench/tb_spi_bridge.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_spi_bridge
FILELIST  := spi_bridge.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Mdir $(BUILD_DIR)

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
